// ==== design/bk_audio_mixer.sv ====
// Stereo mix of the speaker bits and the Covox bytes into unsigned 16-bit samples
`default_nettype none
`timescale 1ns/1ns

module bk_audio_mixer
	import bk_bus_pkg::*;
	import bk_io_pkg::*;
(
	input  logic          clk_sys,
	input  logic          arst_n,
	input  logic          covox_enable,
	input  spk_t          spk,
	input  bk_word_t      covox_word,
	output audio_sample_t audio_l,
	output audio_sample_t audio_r
);

	logic [9:0] mix_l;
	logic [9:0] mix_r;

	// Covox byte doubled plus speaker at a quarter of full scale
	function automatic logic [9:0] mix_channel(input logic [7:0] sample, input spk_t spk_bits,
	                                           input logic covox_on);
		logic [9:0] covox_sum;
		covox_sum = {1'b0, sample, 1'b0} + {2'b00, spk_bits, 5'b00000};
		return covox_on ? covox_sum : {spk_bits, 7'b0000000};
	endfunction

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mix_l <= '0;
			mix_r <= '0;
		end else begin
			mix_l <= mix_channel(covox_word[7:0], spk, covox_enable);
			mix_r <= mix_channel(covox_word[15:8], spk, covox_enable);
		end
	end

	assign audio_l = {mix_l, 6'd0};
	assign audio_r = {mix_r, 6'd0};

endmodule

`default_nettype wire

// ==== design/bk_bus_pkg.sv ====
// Bus-side types for the I/O block: Wishbone request/response structs and register addresses
`default_nettype none

package bk_bus_pkg;

	// Data word and byte address of the PDP-11 style bus
	typedef logic [15:0] bk_word_t;
	typedef logic [15:0] bk_addr_t;

	// Byte lanes, bit 0 low byte, bit 1 high byte
	typedef logic [1:0] bk_sel_t;

	// Wishbone classic master request
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		bk_sel_t  sel;
		bk_addr_t adr;
		bk_word_t dat;
	} wb_req_t;

	// Registered slave answer
	typedef struct packed {
		logic     ack;
		logic     err;
		bk_word_t dat;
	} wb_rsp_t;

	// One-cycle write strobe from the decoder to a register block
	typedef struct packed {
		logic     valid;
		bk_sel_t  sel;
		bk_word_t data;
	} bus_wr_t;

	localparam bk_addr_t SYSREG_ADDR = 16'o177716;
	localparam bk_addr_t PORT_ADDR   = 16'o177714;

endpackage

`default_nettype wire

// ==== design/bk_clock_enables.sv ====
// CPU phase clock enables from clk_sys; model selects the period, turbo halves it
`default_nettype none
`timescale 1ns/1ns

module bk_clock_enables
	import bk_io_pkg::*;
(
	input  logic clk_sys,
	input  logic arst_n,
	input  logic bk0010,
	input  logic turbo_req,
	input  logic cpu_sync,
	output logic ce_cpu_p,
	output logic ce_cpu_n
);

	cpu_div_t cpu_div;
	cpu_div_t div_top;
	cpu_div_t neg_pos;
	logic     turbo;

	// Last count of the period and position of the negative phase
	always_comb begin
		div_top = (CPU_DIV_BASE + (bk0010 ? CPU_DIV_BK0010_ADD : 5'd0)) >> turbo;
		neg_pos = (CPU_NEG_BASE + (bk0010 ? CPU_NEG_BK0010_ADD : 5'd0)) >> turbo;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cpu_div  <= '0;
			turbo    <= 1'b0;
			ce_cpu_p <= 1'b0;
			ce_cpu_n <= 1'b0;
		end else begin
			if (cpu_div == div_top) begin
				cpu_div <= '0;
				// Speed change only between bus cycles
				if (!cpu_sync)
					turbo <= turbo_req;
			end else begin
				cpu_div <= cpu_div + 5'd1;
			end
			ce_cpu_p <= (cpu_div == 5'd0);
			ce_cpu_n <= (cpu_div == neg_pos);
		end
	end

	a_phase_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(ce_cpu_p && ce_cpu_n));

endmodule

`default_nettype wire

// ==== design/bk_io_decode.sv ====
// Wishbone classic slave front end: decodes the two registers, answers ack or err one cycle later
`default_nettype none
`timescale 1ns/1ns

module bk_io_decode
	import bk_bus_pkg::*;
(
	input  logic     clk_sys,
	input  logic     arst_n,
	input  wb_req_t  wb_req,
	output wb_rsp_t  wb_rsp,
	input  bk_word_t sys_rdata,
	input  bk_word_t port_rdata,
	output logic     sys_start,
	output logic     sys_we,
	output bus_wr_t  sys_wr,
	output bus_wr_t  port_wr
);

	logic     req_live;
	logic     req_seen;
	logic     req_start;
	logic     hit_sys;
	logic     hit_port;
	logic     ack_q;
	logic     err_q;
	logic     sys_wr_q;
	logic     port_wr_q;
	bk_word_t rdata_mux;
	bk_word_t dat_q;
	bk_word_t wr_data_q;
	bk_sel_t  wr_sel_q;

	// First cycle of a request, master keeps stb up until it sees the answer
	assign req_live  = wb_req.cyc & wb_req.stb;
	assign req_start = req_live & ~req_seen;

	assign hit_sys  = (wb_req.adr == SYSREG_ADDR);
	assign hit_port = (wb_req.adr == PORT_ADDR);

	// Unmapped reads give zero
	assign rdata_mux = hit_sys  ? sys_rdata :
	                   hit_port ? port_rdata : '0;

	//////////////////////////////////////////////////
	// Handshake and strobes

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			req_seen  <= 1'b0;
			ack_q     <= 1'b0;
			err_q     <= 1'b0;
			sys_start <= 1'b0;
			sys_wr_q  <= 1'b0;
			port_wr_q <= 1'b0;
		end else begin
			req_seen  <= req_live;
			ack_q     <= req_start & (hit_sys | hit_port);
			err_q     <= req_start & ~(hit_sys | hit_port);
			sys_start <= req_start & hit_sys;
			sys_wr_q  <= req_start & hit_sys & wb_req.we;
			port_wr_q <= req_start & hit_port & wb_req.we;
		end
	end

	// Data side of the answer, captured with the request
	always_ff @(posedge clk_sys) begin
		if (req_start) begin
			dat_q     <= rdata_mux;
			sys_we    <= wb_req.we;
			wr_sel_q  <= wb_req.sel;
			wr_data_q <= wb_req.dat;
		end
	end

	assign wb_rsp  = '{ack: ack_q, err: err_q, dat: dat_q};
	assign sys_wr  = '{valid: sys_wr_q, sel: wr_sel_q, data: wr_data_q};
	assign port_wr = '{valid: port_wr_q, sel: wr_sel_q, data: wr_data_q};

	a_ack_err_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(ack_q && err_q));

	a_answer_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(ack_q || err_q) |=> !(ack_q || err_q));

endmodule

`default_nettype wire

// ==== design/bk_io_pkg.sv ====
// I/O-side types for the block: mouse packet and state, audio sample and CPU divider constants
`default_nettype none

package bk_io_pkg;

	// Packet from the host mouse, new data on every toggle change
	typedef struct packed {
		logic       toggle;
		logic [7:0] dy;
		logic [7:0] dx;
		logic [1:0] rsvd_hi;
		logic       sign_y;
		logic       sign_x;
		logic [1:0] rsvd_lo;
		logic [1:0] buttons;
	} mouse_pkt_t;

	// 0 up, 1 right, 2 down, 3 left, 5 left button, 6 right button
	typedef logic [6:0] mouse_state_t;

	typedef logic [2:0]  spk_t;
	typedef logic [15:0] audio_sample_t;
	typedef logic [4:0]  cpu_div_t;

	// CPU phase divider, halved in turbo
	localparam cpu_div_t CPU_DIV_BASE       = 5'd23;
	localparam cpu_div_t CPU_DIV_BK0010_ADD = 5'd8;
	localparam cpu_div_t CPU_NEG_BASE       = 5'd12;
	localparam cpu_div_t CPU_NEG_BK0010_ADD = 5'd4;

	// Minimum mouse movement that counts as a direction
	localparam int unsigned MOUSE_POS_THRESH = 3;
	localparam int unsigned MOUSE_NEG_THRESH = 2;

endpackage

`default_nettype wire

// ==== design/bk_io_top.sv ====
// Top of the BK0010/BK0011M I/O block, joins the bus front end, registers, mixer and clock enables
`default_nettype none
`timescale 1ns/1ns

module bk_io_top
	import bk_bus_pkg::*;
	import bk_io_pkg::*;
(
	input  logic          clk_sys,
	input  logic          arst_n,
	input  wb_req_t       wb_req,
	output wb_rsp_t       wb_rsp,
	input  logic          bk0010,
	input  logic          turbo_req,
	input  logic          cpu_sync,
	input  logic          covox_enable,
	input  logic          key_down,
	input  logic          key_stop,
	input  logic [7:0]    start_addr,
	input  bk_word_t      joystick_0,
	input  bk_word_t      joystick_1,
	input  mouse_pkt_t    mouse,
	output logic          ce_cpu_p,
	output logic          ce_cpu_n,
	output logic          stop_irq,
	output audio_sample_t audio_l,
	output audio_sample_t audio_r
);

	bk_word_t sys_rdata;
	bk_word_t port_rdata;
	bk_word_t covox_word;
	logic     sys_start;
	logic     sys_we;
	bus_wr_t  sys_wr;
	bus_wr_t  port_wr;
	spk_t     spk;

	bk_clock_enables u_clock_enables (.*);

	bk_io_decode u_io_decode (.*);

	bk_system_reg u_system_reg (.*, .rdata(sys_rdata));

	bk_user_port u_user_port (.*, .rdata(port_rdata));

	bk_audio_mixer u_audio_mixer (.*);

endmodule

`default_nettype wire

// ==== design/bk_system_reg.sv ====
// System register at 177716: supervisor flag, speaker bits, STOP-key block and start address
`default_nettype none
`timescale 1ns/1ns

module bk_system_reg
	import bk_bus_pkg::*;
	import bk_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       bk0010,
	input  logic       key_down,
	input  logic       key_stop,
	input  logic [7:0] start_addr,
	input  logic       sys_start,
	input  logic       sys_we,
	input  bus_wr_t    sys_wr,
	output bk_word_t   rdata,
	output spk_t       spk,
	output logic       stop_irq
);

	logic super_flg;
	logic stop_block;
	logic spk_load;
	logic block_load;

	// Low byte written, high byte either untouched or bit 11 clear
	assign spk_load = sys_wr.valid & sys_wr.sel[0] &
	                  (~sys_wr.sel[1] | ~sys_wr.data[11]);

	assign block_load = sys_wr.valid & sys_wr.sel[1] & ~sys_wr.data[11];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			super_flg  <= 1'b0;
			stop_block <= 1'b0;
			spk        <= '0;
		end else begin
			// Flag remembers the direction of the last access
			if (sys_start)
				super_flg <= sys_we;
			if (spk_load)
				spk <= {sys_wr.data[6], sys_wr.data[5], sys_wr.data[2] & ~bk0010};
			if (block_load)
				stop_block <= sys_wr.data[12];
		end
	end

	assign stop_irq = key_stop & ~stop_block;

	// start_addr | 1 | ~key_down | 000 | supervisor | 00
	assign rdata = {start_addr, 1'b1, ~key_down, 3'b000, super_flg, 2'b00};

	// Every write arrives with an access start, so the flag reads back as set afterwards
	a_write_sets_flag: assert property (@(posedge clk_sys) disable iff (!arst_n)
		sys_wr.valid |=> super_flg);

endmodule

`default_nettype wire

// ==== design/bk_user_port.sv ====
// User port at 177714: joystick or mouse readback on reads, mouse enable or Covox bytes on writes
`default_nettype none
`timescale 1ns/1ns

module bk_user_port
	import bk_bus_pkg::*;
	import bk_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       covox_enable,
	input  bk_word_t   joystick_0,
	input  bk_word_t   joystick_1,
	input  mouse_pkt_t mouse,
	input  bus_wr_t    port_wr,
	output bk_word_t   rdata,
	output bk_word_t   covox_word
);

	bk_word_t     joy;
	mouse_state_t mouse_state;
	logic         toggle_q;
	logic         mouse_change;
	logic         mouse_mode;
	logic         mouse_en;
	logic         enable_wr;
	logic         covox_wr;
	logic [8:0]   dx_ext;
	logic [8:0]   dy_ext;
	logic [8:0]   dx_inv;
	logic [8:0]   dy_inv;
	logic         up_hit;
	logic         down_hit;
	logic         right_hit;
	logic         left_hit;

	assign joy          = joystick_0 | joystick_1;
	assign mouse_change = (mouse.toggle != toggle_q);
	assign enable_wr    = port_wr.valid & ~covox_enable & port_wr.sel[0];
	assign covox_wr     = port_wr.valid & covox_enable;

	//////////////////////////////////////////////////
	// Mouse deltas, sign bit on top
	assign dx_ext = {mouse.sign_x, mouse.dx};
	assign dy_ext = {mouse.sign_y, mouse.dy};
	assign dx_inv = ~dx_ext;
	assign dy_inv = ~dy_ext;

	assign up_hit    = ~dy_ext[8] & (dy_ext > MOUSE_POS_THRESH);
	assign down_hit  =  dy_ext[8] & (dy_inv > MOUSE_NEG_THRESH);
	assign right_hit = ~dx_ext[8] & (dx_ext > MOUSE_POS_THRESH);
	assign left_hit  =  dx_ext[8] & (dx_inv > MOUSE_NEG_THRESH);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q    <= 1'b0;
			mouse_mode  <= 1'b0;
			mouse_en    <= 1'b0;
			mouse_state <= '0;
			covox_word  <= '0;
		end else begin
			toggle_q <= mouse.toggle;
			// Any joystick activity hands the port back to the joysticks
			if (|joy)
				mouse_mode <= 1'b0;
			if (enable_wr) begin
				mouse_en <= port_wr.data[3];
				if (!port_wr.data[3])
					mouse_state[3:0] <= 4'b0000;
			end
			if (covox_wr) begin
				if (port_wr.sel[0])
					covox_word[7:0] <= port_wr.data[7:0];
				if (port_wr.sel[1])
					covox_word[15:8] <= port_wr.data[15:8];
			end
			if (mouse_change) begin
				mouse_mode     <= 1'b1;
				mouse_state[6] <= mouse.buttons[1];
				mouse_state[5] <= mouse.buttons[0];
				// Directions latch until the program clears them
				if (mouse_en) begin
					if (!mouse_state[0] && !mouse_state[2]) begin
						if (up_hit)
							mouse_state[0] <= 1'b1;
						if (down_hit)
							mouse_state[2] <= 1'b1;
					end
					if (!mouse_state[1] && !mouse_state[3]) begin
						if (right_hit)
							mouse_state[1] <= 1'b1;
						if (left_hit)
							mouse_state[3] <= 1'b1;
					end
				end
			end
		end
	end

	assign rdata = (~covox_enable & mouse_mode) ? {9'b0, mouse_state} : joy;

	a_axis_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(mouse_state[0] && mouse_state[2]) && !(mouse_state[1] && mouse_state[3]));

endmodule

`default_nettype wire

// ==== project.f ====
design/bk_bus_pkg.sv
design/bk_io_pkg.sv
design/bk_clock_enables.sv
design/bk_io_decode.sv
design/bk_system_reg.sv
design/bk_user_port.sv
design/bk_audio_mixer.sv
design/bk_io_top.sv
sim/tb_clock_gen.sv
sim/tb_bk_io.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_bk_io
./obj_dir/Vtb_bk_io | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

// ==== sim/tb_bk_io.sv ====
// Top-level testbench run under Verilator that checks the BK I/O block against its stimulus table
`default_nettype none
`timescale 1ns/1ns

module tb_bk_io
	import bk_bus_pkg::*;
	import bk_io_pkg::*;
();

	localparam bk_addr_t SR = SYSREG_ADDR;
	localparam bk_addr_t UP = PORT_ADDR;
	localparam int RAND_ROUNDS = 16;

	// Last divider count and ce_cpu_n delay for combo {bk0010, turbo_req} from 0 to 3
	localparam cpu_div_t EXP_TOP[4] = '{5'd23, 5'd11, 5'd31, 5'd15};
	localparam cpu_div_t EXP_NEG[4] = '{5'd12, 5'd6, 5'd16, 5'd8};

	// Mode is {bk0010, covox_enable, key_down}
	typedef struct packed {
		logic [2:0]    mode;
		mouse_pkt_t    mouse;
		bk_word_t      joy;
		bk_addr_t      adr;
		logic          we;
		bk_sel_t       sel;
		bk_word_t      dat;
		logic          exp_err;
		bk_word_t      exp_rd;
		audio_sample_t exp_l;
		audio_sample_t exp_r;
		logic          exp_stop;
	} row_t;

	logic          clk_sys;
	logic          arst_n;
	wb_req_t       wb_req;
	wb_rsp_t       wb_rsp;
	logic          bk0010, turbo_req, cpu_sync, covox_enable, key_down, key_stop;
	logic [7:0]    start_addr;
	bk_word_t      joystick_0, joystick_1;
	mouse_pkt_t    mouse;
	logic          ce_cpu_p, ce_cpu_n, stop_irq;
	audio_sample_t audio_l, audio_r;

	row_t        rows[$];
	int          value_errors = 0;
	int          proto_errors = 0;
	logic        table_ready = 1'b0;
	logic [31:0] rnd = 32'h7fe33bfe;

	tb_clock_gen u_clock_gen (.clk_sys(clk_sys), .arst_n(arst_n));

	bk_io_top dut (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Covox level is the byte times two plus the speaker times 32 in the top ten bits
	function automatic audio_sample_t covox_sample(input logic [7:0] b, input spk_t s);
		int level;
		level = 2 * b + 32 * s;
		return audio_sample_t'(level * 64);
	endfunction

	task automatic check_word(input string what, input bk_word_t got, input bk_word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask
	task automatic check_sample(input string what, input audio_sample_t got,
			input audio_sample_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask
	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask
	task automatic check_div(input string what, input cpu_div_t got, input cpu_div_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic add_row(input logic [2:0] mode, input mouse_pkt_t m, input bk_word_t joy,
			input bk_addr_t adr, input logic we, input bk_sel_t sel, input bk_word_t dat,
			input logic exp_err, input bk_word_t exp_rd, input audio_sample_t exp_l,
			input audio_sample_t exp_r, input logic exp_stop);
		rows.push_back(row_t'{mode, m, joy, adr, we, sel, dat, exp_err, exp_rd, exp_l, exp_r,
			exp_stop});
	endtask

	// One Wishbone classic cycle with the answer expected at the second falling edge
	task automatic bus_access(input bk_addr_t adr, input logic we, input bk_sel_t sel,
			input bk_word_t dat, output logic got_err, output bk_word_t got_rd);
		int   waited;
		logic answered;
		answered = 1'b0;
		got_err = 1'b0;
		got_rd = '0;
		@(posedge clk_sys);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
		for (waited = 0; waited < 8 && !answered; waited++) begin
			@(negedge clk_sys);
			if (wb_rsp.ack && wb_rsp.err) begin
				proto_errors++;
				$display("ack and err were high together at %0t ns", $time);
			end
			if (wb_rsp.ack || wb_rsp.err) begin
				answered = 1'b1;
				got_err = wb_rsp.err;
				got_rd = wb_rsp.dat;
				if (waited != 1) begin
					proto_errors++;
					$display("Answer for address %o came in the wrong cycle at %0t ns", adr, $time);
				end
			end
		end
		if (!answered) begin
			proto_errors++;
			$display("No ack or err for address %o within 8 cycles", adr);
		end
		@(posedge clk_sys);
		wb_req <= '0;
		@(negedge clk_sys);
		if (wb_rsp.ack || wb_rsp.err) begin
			proto_errors++;
			$display("Answer for address %o lasted more than one cycle", adr);
		end
	endtask

	// Cycles between two ce_cpu_p pulses and from the first one to ce_cpu_n
	// Both stay at -1 when a pulse is missing
	task automatic measure_ce(output int spacing, output int delay);
		int cyc;
		int p_seen;
		int t_p;
		spacing = -1;
		delay = -1;
		p_seen = 0;
		t_p = 0;
		for (cyc = 0; cyc < 200 && spacing < 0; cyc++) begin
			@(negedge clk_sys);
			if (ce_cpu_n && p_seen == 1 && delay < 0)
				delay = cyc - t_p;
			if (ce_cpu_p) begin
				if (p_seen == 1)
					spacing = cyc - t_p;
				else
					t_p = cyc;
				p_seen++;
			end
		end
	endtask

	initial begin
		wait (table_ready);
		repeat (rows.size() * 40 + 2000) @(posedge clk_sys);
		$display("Watchdog expired, the run did not finish in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		row_t       r;
		mouse_pkt_t m0, m1, m2, m3;
		logic       got_err;
		bk_word_t   got_rd, cov, joy_or;
		bk_addr_t   bad_adr;
		int         spacing, delay, combo;
		cpu_div_t   exp_top, exp_neg;
		wb_req <= '0;
		bk0010 <= 1'b0;
		turbo_req <= 1'b0;
		cpu_sync <= 1'b0;
		covox_enable <= 1'b0;
		key_down <= 1'b0;
		key_stop <= 1'b1;
		start_addr <= 8'h5A;
		joystick_0 <= '0;
		joystick_1 <= '0;
		mouse <= '0;
		// toggle, dy, dx, reserved, sign_y, sign_x, reserved, buttons
		m0 = '0;
		m1 = {1'b1, 8'd4, 8'd3, 2'b00, 1'b0, 1'b0, 2'b00, 2'b01};
		m2 = {1'b0, 8'd0, 8'hFD, 2'b00, 1'b0, 1'b1, 2'b00, 2'b00};
		m3 = {1'b1, 8'd0, 8'hFC, 2'b00, 1'b0, 1'b1, 2'b00, 2'b10};

		// System register flag, speaker lanes and STOP block
		add_row(3'b000, m0, 'h0, SR, 0, 2'b11, 'h0000, 0, 'h5AC0, 'h0000, 'h0000, 1);
		add_row(3'b000, m0, 'h0, SR, 1, 2'b01, 'h0064, 0, 'h0000, 'hE000, 'hE000, 1);
		add_row(3'b001, m0, 'h0, SR, 0, 2'b11, 'h0000, 0, 'h5A84, 'hE000, 'hE000, 1);
		add_row(3'b000, m0, 'h0, SR, 0, 2'b11, 'h0000, 0, 'h5AC0, 'hE000, 'hE000, 1);
		add_row(3'b000, m0, 'h0, SR, 1, 2'b11, 'h0820, 0, 'h0000, 'hE000, 'hE000, 1);
		add_row(3'b000, m0, 'h0, SR, 1, 2'b11, 'h1020, 0, 'h0000, 'h4000, 'h4000, 0);
		add_row(3'b000, m0, 'h0, SR, 1, 2'b10, 'h0044, 0, 'h0000, 'h4000, 'h4000, 1);
		add_row(3'b100, m0, 'h0, SR, 1, 2'b01, 'h0004, 0, 'h0000, 'h0000, 'h0000, 1);
		add_row(3'b100, m0, 'h0, SR, 1, 2'b01, 'h0064, 0, 'h0000, 'hC000, 'hC000, 1);
		add_row(3'b000, m0, 'h0, SR, 1, 2'b01, 'h0000, 0, 'h0000, 'h0000, 'h0000, 1);
		add_row(3'b000, m0, 'h0, UP, 0, 2'b11, 'h0000, 0, 'h0000, 'h0000, 'h0000, 1);
		add_row(3'b000, m0, 'h0, 16'o177712, 0, 2'b11, 'h0, 1, 'h0000, 'h0, 'h0, 1);
		// Mouse at and above the thresholds and then the joystick takes over
		add_row(3'b000, m0, 'h0, UP, 1, 2'b01, 'h0008, 0, 'h0000, 'h0000, 'h0000, 1);
		add_row(3'b000, m1, 'h0, UP, 0, 2'b11, 'h0000, 0, 'h0021, 'h0000, 'h0000, 1);
		add_row(3'b000, m2, 'h0, UP, 0, 2'b11, 'h0000, 0, 'h0001, 'h0000, 'h0000, 1);
		add_row(3'b000, m3, 'h0, UP, 0, 2'b11, 'h0000, 0, 'h0049, 'h0000, 'h0000, 1);
		add_row(3'b000, m3, 'h0, UP, 1, 2'b01, 'h0000, 0, 'h0000, 'h0000, 'h0000, 1);
		add_row(3'b000, m3, 'h0, UP, 0, 2'b11, 'h0000, 0, 'h0040, 'h0000, 'h0000, 1);
		add_row(3'b000, m3, 'h12, UP, 0, 2'b11, 'h0000, 0, 'h0012, 'h0000, 'h0000, 1);
		// Covox byte lanes mixed with the speaker
		add_row(3'b010, m3, 'h0, UP, 1, 2'b01, 'h1234, 0, 'h0000, 'h1A00, 'h0000, 1);
		add_row(3'b010, m3, 'h0, UP, 1, 2'b10, 'hAB00, 0, 'h0000, 'h1A00, 'h5580, 1);
		add_row(3'b010, m3, 'h0, SR, 1, 2'b01, 'h0064, 0, 'h0000, 'h5200, 'h8D80, 1);
		add_row(3'b010, m3, 'h0, UP, 0, 2'b11, 'h0000, 0, 'h0000, 'h5200, 'h8D80, 1);
		table_ready = 1'b1;
		wait (arst_n === 1'b1);

		foreach (rows[i]) begin
			r = rows[i];
			@(posedge clk_sys);
			bk0010 <= r.mode[2];
			covox_enable <= r.mode[1];
			key_down <= r.mode[0];
			mouse <= r.mouse;
			joystick_0 <= r.joy;
			repeat (3) @(posedge clk_sys);
			bus_access(r.adr, r.we, r.sel, r.dat, got_err, got_rd);
			check_flag($sformatf("row %0d err", i), got_err, r.exp_err);
			if (!r.we || r.exp_err)
				check_word($sformatf("row %0d read data", i), got_rd, r.exp_rd);
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
			check_sample($sformatf("row %0d audio_l", i), audio_l, r.exp_l);
			check_sample($sformatf("row %0d audio_r", i), audio_r, r.exp_r);
			check_flag($sformatf("row %0d stop_irq", i), stop_irq, r.exp_stop);
		end

		//////////////////////////////////////////////////
		// Random joysticks, Covox words and unmapped addresses with the speaker left at 3'b111
		for (int n = 0; n < RAND_ROUNDS; n++) begin
			rnd = xorshift(rnd);
			joy_or = rnd[15:0] | rnd[31:16];
			@(posedge clk_sys);
			joystick_0 <= rnd[15:0];
			joystick_1 <= rnd[31:16];
			rnd = xorshift(rnd);
			cov = rnd[15:0];
			bus_access(UP, 1'b1, 2'b11, cov, got_err, got_rd);
			bus_access(UP, 1'b0, 2'b11, '0, got_err, got_rd);
			check_flag("port read err", got_err, 1'b0);
			check_word("joystick OR", got_rd, joy_or);
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
			check_sample("random audio_l", audio_l, covox_sample(cov[7:0], 3'b111));
			check_sample("random audio_r", audio_r, covox_sample(cov[15:8], 3'b111));
			rnd = xorshift(rnd);
			bad_adr = rnd[15:0];
			if (bad_adr == SYSREG_ADDR || bad_adr == PORT_ADDR)
				bad_adr = 16'o177710;
			bus_access(bad_adr, rnd[16], 2'b11, rnd[31:16], got_err, got_rd);
			check_flag("unmapped err", got_err, 1'b1);
			check_word("unmapped data", got_rd, '0);
		end

		//////////////////////////////////////////////////
		// Clock enables for every combo of {bk0010, turbo_req}
		for (combo = 0; combo < 4; combo++) begin
			@(posedge clk_sys);
			bk0010 <= combo[1];
			turbo_req <= combo[0];
			measure_ce(spacing, delay);
			measure_ce(spacing, delay);
			measure_ce(spacing, delay);
			exp_top = EXP_TOP[combo];
			exp_neg = EXP_NEG[combo];
			if (spacing < 0 || delay < 0) begin
				proto_errors++;
				$display("No ce_cpu_p and ce_cpu_n pulses seen for mode %0d", combo);
			end else begin
				check_div($sformatf("mode %0d period", combo), cpu_div_t'(spacing - 1), exp_top);
				check_div($sformatf("mode %0d neg delay", combo), cpu_div_t'(delay), exp_neg);
			end
		end

		$display("Errors: %0d value mismatches, %0d handshake or timing problems",
			value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset source: 20 ns clk_sys, arst_n held low for the first 4 cycles
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk_sys);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire
